//--- src/bft_leaf_pkg.sv
`default_nettype none

package bft_leaf_pkg;

    // Tree packet and user payload widths
    localparam int PACKET_BITS   = 49;
    localparam int PAYLOAD_BITS  = 32;
    localparam int NUM_LEAF_BITS = 5;
    localparam int NUM_PORT_BITS = 4;
    localparam int NUM_ADDR_BITS = 7;

    // User ports on this leaf, numbered from 1
    localparam int NUM_IN_PORTS  = 7;
    localparam int NUM_OUT_PORTS = 7;

    // Payloads buffered per input port, equal to the tree's initial credits per port
    localparam int FIFO_DEPTH    = 4;
    localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);

    // Credits the leaf holds toward the tree after reset
    localparam int TX_CREDITS    = 4;

    localparam int CFG_ADDR_BITS = 4;

    // Packet field positions, valid bit on top and payload at the bottom
    localparam int PKT_VALID_BIT = PACKET_BITS - 1;
    localparam int PKT_LEAF_LSB  = PKT_VALID_BIT - NUM_LEAF_BITS;
    localparam int PKT_PORT_LSB  = PKT_LEAF_LSB - NUM_PORT_BITS;
    localparam int PKT_ADDR_LSB  = PKT_PORT_LSB - NUM_ADDR_BITS;

    // Configuration map
    localparam int CFG_OWN_ID_ADDR = 0;

    // Route entry layout inside cfg_wdata
    localparam int ROUTE_PORT_LSB = 0;
    localparam int ROUTE_LEAF_LSB = ROUTE_PORT_LSB + NUM_PORT_BITS;

    typedef logic [PACKET_BITS-1:0]   packet_t;
    typedef logic [PAYLOAD_BITS-1:0]  payload_t;
    typedef logic [NUM_LEAF_BITS-1:0] leaf_id_t;
    typedef logic [NUM_PORT_BITS-1:0] port_id_t;
    typedef logic [NUM_ADDR_BITS-1:0] pkt_addr_t;
    typedef logic [CFG_ADDR_BITS-1:0] cfg_addr_t;

    // Wide enough to hold the value 4 for both credit and occupancy counts
    typedef logic [2:0] credit_cnt_t;

    typedef logic [FIFO_PTR_BITS-1:0] fifo_ptr_t;

endpackage

`default_nettype wire

//--- src/port_fifo.sv
`default_nettype none

module port_fifo (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         push,
    input  wire bft_leaf_pkg::payload_t push_data,
    input  wire                         pop,
    output bft_leaf_pkg::payload_t      head,
    output logic                        not_empty
);
    import bft_leaf_pkg::*;

    payload_t    mem [FIFO_DEPTH];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    credit_cnt_t count;

    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

    // A push into a full FIFO means the tree sent without holding a credit
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count < credit_cnt_t'(FIFO_DEPTH)));

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> (count != '0));

endmodule

`default_nettype wire

//--- src/leaf_config_regs.sv
`default_nettype none

module leaf_config_regs (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            cfg_wr,
    input  wire bft_leaf_pkg::cfg_addr_t   cfg_addr,
    input  wire bft_leaf_pkg::payload_t    cfg_wdata,
    output bft_leaf_pkg::payload_t         cfg_rdata,
    output bft_leaf_pkg::leaf_id_t         own_leaf_id,
    output bft_leaf_pkg::leaf_id_t [bft_leaf_pkg::NUM_OUT_PORTS-1:0] route_leaf,
    output bft_leaf_pkg::port_id_t [bft_leaf_pkg::NUM_OUT_PORTS-1:0] route_port
);
    import bft_leaf_pkg::*;

    // Address 0 is the own ID, addresses 1 to 7 are the routes of output ports 1 to 7
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            own_leaf_id <= '0;
            route_leaf  <= '0;
            route_port  <= '0;
        end else if (cfg_wr) begin
            if (cfg_addr == cfg_addr_t'(CFG_OWN_ID_ADDR)) begin
                own_leaf_id <= cfg_wdata[NUM_LEAF_BITS-1:0];
            end
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                if (cfg_addr == cfg_addr_t'(i + 1)) begin
                    route_leaf[i] <= cfg_wdata[ROUTE_LEAF_LSB +: NUM_LEAF_BITS];
                    route_port[i] <= cfg_wdata[ROUTE_PORT_LSB +: NUM_PORT_BITS];
                end
            end
        end
    end

    // Unmapped addresses fall through and read as zero
    always_comb begin
        cfg_rdata = '0;
        if (cfg_addr == cfg_addr_t'(CFG_OWN_ID_ADDR)) begin
            cfg_rdata[NUM_LEAF_BITS-1:0] = own_leaf_id;
        end
        for (int i = 0; i < NUM_OUT_PORTS; i++) begin
            if (cfg_addr == cfg_addr_t'(i + 1)) begin
                cfg_rdata[ROUTE_LEAF_LSB +: NUM_LEAF_BITS] = route_leaf[i];
                cfg_rdata[ROUTE_PORT_LSB +: NUM_PORT_BITS] = route_port[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/leaf_packet_rx.sv
`default_nettype none

module leaf_packet_rx (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire bft_leaf_pkg::packet_t         din_leaf_bft2interface,
    input  wire bft_leaf_pkg::leaf_id_t        own_leaf_id,
    input  wire [bft_leaf_pkg::NUM_IN_PORTS-1:0] ack_user2interface,
    output bft_leaf_pkg::payload_t [bft_leaf_pkg::NUM_IN_PORTS-1:0] dout_leaf_interface2user,
    output logic [bft_leaf_pkg::NUM_IN_PORTS-1:0] vld_interface2user,
    output logic                               credit_out,
    output bft_leaf_pkg::port_id_t             credit_out_port
);
    import bft_leaf_pkg::*;

    logic                    pkt_valid;
    leaf_id_t                dst_leaf;
    port_id_t                dst_port;
    payload_t                payload;
    logic                    accept;
    logic                    drop;
    logic [NUM_IN_PORTS-1:0] pop;
    logic                    pop_any;
    port_id_t                pop_port;
    logic                    send_valid;
    port_id_t                send_port;
    logic                    enq;
    logic                    deq;
    port_id_t                q_port [2];
    logic [1:0]              q_count;

    assign pkt_valid = din_leaf_bft2interface[PKT_VALID_BIT];
    assign dst_leaf  = din_leaf_bft2interface[PKT_LEAF_LSB +: NUM_LEAF_BITS];
    assign dst_port  = din_leaf_bft2interface[PKT_PORT_LSB +: NUM_PORT_BITS];
    assign payload   = din_leaf_bft2interface[PAYLOAD_BITS-1:0];

    assign accept = pkt_valid && (dst_leaf == own_leaf_id) && (dst_port != '0)
                    && (dst_port <= port_id_t'(NUM_IN_PORTS));
    assign drop   = pkt_valid && !accept;
    assign pop    = ack_user2interface & vld_interface2user;

    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_port
        port_fifo port_fifo_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (accept && (dst_port == port_id_t'(i + 1))),
            .push_data (payload),
            .pop       (pop[i]),
            .head      (dout_leaf_interface2user[i]),
            .not_empty (vld_interface2user[i])
        );
    end

    // The user acks one port at a time, take the lowest if several appear
    always_comb begin
        pop_any  = 1'b0;
        pop_port = '0;
        for (int i = NUM_IN_PORTS - 1; i >= 0; i--) begin
            if (pop[i]) begin
                pop_any  = 1'b1;
                pop_port = port_id_t'(i + 1);
            end
        end
    end

    // Pop credits go out at once, drops wait in the queue behind them
    always_comb begin
        send_valid = 1'b0;
        send_port  = '0;
        enq        = 1'b0;
        deq        = 1'b0;
        if (pop_any) begin
            send_valid = 1'b1;
            send_port  = pop_port;
            enq        = drop;
        end else if (q_count != '0) begin
            send_valid = 1'b1;
            send_port  = q_port[0];
            deq        = 1'b1;
            enq        = drop;
        end else if (drop) begin
            send_valid = 1'b1;
            send_port  = dst_port;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_count         <= '0;
            credit_out      <= 1'b0;
            credit_out_port <= '0;
        end else begin
            credit_out      <= send_valid;
            credit_out_port <= send_port;
            case ({enq, deq})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case ({enq, deq})
            2'b10: q_port[q_count[0]] <= dst_port;
            2'b01: q_port[0] <= q_port[1];
            2'b11: begin
                if (q_count == 2'd1) begin
                    q_port[0] <= dst_port;
                end else begin
                    q_port[0] <= q_port[1];
                    q_port[1] <= dst_port;
                end
            end
            default: ;
        endcase
    end

    a_ack_needs_vld: assert property (@(posedge clk) disable iff (!rst_n)
        (ack_user2interface & ~vld_interface2user) == '0);

endmodule

`default_nettype wire

//--- src/leaf_packet_tx.sv
`default_nettype none

module leaf_packet_tx (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire [bft_leaf_pkg::NUM_OUT_PORTS-1:0]  vld_user2interface,
    input  wire bft_leaf_pkg::payload_t [bft_leaf_pkg::NUM_OUT_PORTS-1:0] din_leaf_user2interface,
    input  wire bft_leaf_pkg::leaf_id_t [bft_leaf_pkg::NUM_OUT_PORTS-1:0] route_leaf,
    input  wire bft_leaf_pkg::port_id_t [bft_leaf_pkg::NUM_OUT_PORTS-1:0] route_port,
    input  wire                                    credit_in,
    output logic [bft_leaf_pkg::NUM_OUT_PORTS-1:0] ack_interface2user,
    output bft_leaf_pkg::packet_t                  dout_leaf_interface2bft
);
    import bft_leaf_pkg::*;

    port_id_t    rr_ptr;
    credit_cnt_t credit_cnt;
    logic        found;
    int          grant_idx;
    logic        grant_valid;
    logic        out_valid;
    logic [PACKET_BITS-2:0] out_body;

    // Search starts at the pointer port and wraps past port 7 back to port 1
    always_comb begin
        int idx;
        found              = 1'b0;
        grant_idx          = 0;
        ack_interface2user = '0;
        for (int k = 0; k < NUM_OUT_PORTS; k++) begin
            idx = (int'(rr_ptr) - 1 + k) % NUM_OUT_PORTS;
            if (!found && vld_user2interface[idx]) begin
                found                   = 1'b1;
                grant_idx               = idx;
                ack_interface2user[idx] = (credit_cnt != '0);
            end
        end
    end

    assign grant_valid = found && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr     <= port_id_t'(1);
            credit_cnt <= credit_cnt_t'(TX_CREDITS);
            out_valid  <= 1'b0;
        end else begin
            out_valid <= grant_valid;
            if (grant_valid) begin
                if (grant_idx == NUM_OUT_PORTS - 1) begin
                    rr_ptr <= port_id_t'(1);
                end else begin
                    rr_ptr <= port_id_t'(grant_idx + 2);
                end
            end
            case ({grant_valid, credit_in})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Address field names the sending port so the far end knows the source
    always_ff @(posedge clk) begin
        if (grant_valid) begin
            out_body <= {route_leaf[grant_idx],
                         route_port[grant_idx],
                         pkt_addr_t'(grant_idx + 1),
                         din_leaf_user2interface[grant_idx]};
        end
    end

    assign dout_leaf_interface2bft = {out_valid, out_body};

    // The tree never returns more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= credit_cnt_t'(TX_CREDITS));

    a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(ack_interface2user));

endmodule

`default_nettype wire

//--- src/bft_leaf.sv
`default_nettype none

module bft_leaf (
    input  wire                                    clk,
    input  wire                                    rst_n,

    input  wire                                    cfg_wr,
    input  wire bft_leaf_pkg::cfg_addr_t           cfg_addr,
    input  wire bft_leaf_pkg::payload_t            cfg_wdata,
    output bft_leaf_pkg::payload_t                 cfg_rdata,

    input  wire bft_leaf_pkg::packet_t             din_leaf_bft2interface,
    output bft_leaf_pkg::packet_t                  dout_leaf_interface2bft,
    input  wire                                    credit_in,
    output logic                                   credit_out,
    output bft_leaf_pkg::port_id_t                 credit_out_port,

    output bft_leaf_pkg::payload_t [bft_leaf_pkg::NUM_IN_PORTS-1:0] dout_leaf_interface2user,
    output logic [bft_leaf_pkg::NUM_IN_PORTS-1:0]  vld_interface2user,
    input  wire  [bft_leaf_pkg::NUM_IN_PORTS-1:0]  ack_user2interface,

    input  wire bft_leaf_pkg::payload_t [bft_leaf_pkg::NUM_OUT_PORTS-1:0] din_leaf_user2interface,
    input  wire  [bft_leaf_pkg::NUM_OUT_PORTS-1:0] vld_user2interface,
    output logic [bft_leaf_pkg::NUM_OUT_PORTS-1:0] ack_interface2user
);
    import bft_leaf_pkg::*;

    leaf_id_t                     own_leaf_id;
    leaf_id_t [NUM_OUT_PORTS-1:0] route_leaf;
    port_id_t [NUM_OUT_PORTS-1:0] route_port;

    leaf_config_regs leaf_config_regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .own_leaf_id (own_leaf_id),
        .route_leaf  (route_leaf),
        .route_port  (route_port)
    );

    // Tree to user direction
    leaf_packet_rx leaf_packet_rx_inst (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .own_leaf_id              (own_leaf_id),
        .ack_user2interface       (ack_user2interface),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .credit_out               (credit_out),
        .credit_out_port          (credit_out_port)
    );

    // User to tree direction
    leaf_packet_tx leaf_packet_tx_inst (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .vld_user2interface      (vld_user2interface),
        .din_leaf_user2interface (din_leaf_user2interface),
        .route_leaf              (route_leaf),
        .route_port              (route_port),
        .credit_in               (credit_in),
        .ack_interface2user      (ack_interface2user),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

endmodule

`default_nettype wire

//--- dv/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk
);
    localparam int HALF_PERIOD = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

//--- dv/tb_bft_leaf.sv
`default_nettype none

module tb_bft_leaf;
    import bft_leaf_pkg::*;

    localparam string CASE_FILE = "dv/bft_leaf_cases.txt";

    logic                         clk;
    logic                         rst_n;
    logic                         cfg_wr;
    cfg_addr_t                    cfg_addr;
    payload_t                     cfg_wdata;
    payload_t                     cfg_rdata;
    packet_t                      din_leaf_bft2interface;
    packet_t                      dout_leaf_interface2bft;
    logic                         credit_in;
    logic                         credit_out;
    port_id_t                     credit_out_port;
    payload_t [NUM_IN_PORTS-1:0]  dout_leaf_interface2user;
    logic [NUM_IN_PORTS-1:0]      vld_interface2user;
    logic [NUM_IN_PORTS-1:0]      ack_user2interface;
    payload_t [NUM_OUT_PORTS-1:0] din_leaf_user2interface;
    logic [NUM_OUT_PORTS-1:0]     vld_user2interface;
    logic [NUM_OUT_PORTS-1:0]     ack_interface2user;

    int                       errors = 0;
    int                       cycle_count = 0;
    int                       timeout_cycles = 100;
    int                       seed = 31500;
    int                       tree_credits [16];
    int                       rx_pending [NUM_IN_PORTS];
    int                       tx_credits;
    leaf_id_t                 own_id;
    logic [NUM_OUT_PORTS-1:0] ack_seen = '0;
    packet_t                  sent_pkts [$];

    clk_gen clk_gen_inst (.clk(clk));

    bft_leaf bft_leaf_inst (.*);

    // Mid-cycle sampling of the tree side and the user acks
    always @(negedge clk) begin
        ack_seen = ack_interface2user;
        if (rst_n && credit_out) begin
            tree_credits[credit_out_port]++;
            if (tree_credits[credit_out_port] > FIFO_DEPTH) begin
                errors++;
                $display("Port %0d returned a credit that the tree never spent", credit_out_port);
            end
        end
        if (rst_n && dout_leaf_interface2bft[PACKET_BITS-1]) begin
            if (tx_credits == 0) begin
                errors++;
                $display("The leaf sent a packet while it held no tree credit");
            end
            tx_credits--;
            sent_pkts.push_back(dout_leaf_interface2bft);
        end
        // By now tx_credits matches the credits the leaf holds in this cycle
        if (rst_n && ack_interface2user != '0) begin
            if (!$onehot0(ack_interface2user)
                || (ack_interface2user & ~vld_user2interface) != '0) begin
                errors++;
                $display("Ack %0b names no single waiting user port", ack_interface2user);
            end
            if (tx_credits <= 0) begin
                errors++;
                $display("The leaf acked a user word while it held no tree credit");
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout after %0d cycles with %0d errors, the DUT stopped making progress",
                     cycle_count, errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // The user side drops vld after the edge that took its word
    task automatic next_cycle();
        @(posedge clk);
        #1;
        vld_user2interface = vld_user2interface & ~ack_seen;
    endtask

    task automatic report_mismatch(input logic [8*24-1:0] name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("CHECK FAILED %0s: expected %0h, actual %0h", name, expected, actual);
    endtask

    function automatic logic [NUM_IN_PORTS-1:0] expected_rx_vld();
        logic [NUM_IN_PORTS-1:0] mask;
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            mask[i] = (rx_pending[i] != 0);
        end
        return mask;
    endfunction

    task automatic run_cases();
        int               fd;
        int               rc;
        int               p;
        int               gap;
        logic [8*128-1:0] text;
        logic [8*4-1:0]   op;
        logic [8*24-1:0]  name;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      f3;
        logic [31:0]      f4;
        packet_t          pkt;
        packet_t          exp_pkt;
        fd = $fopen(CASE_FILE, "r");
        while ($fscanf(fd, "%s", op) == 1) begin
            if (op == "#") begin
                rc = $fgets(text, fd);
            end else begin
                rc = $fscanf(fd, "%s", name);
                case (op)
                    "CW": begin
                        rc = $fscanf(fd, "%h %h", f1, f2);
                        cfg_wr    = 1'b1;
                        cfg_addr  = cfg_addr_t'(f1);
                        cfg_wdata = f2;
                        if (f1 == 0) begin
                            own_id = leaf_id_t'(f2);
                        end
                        next_cycle();
                        cfg_wr = 1'b0;
                    end
                    "CR": begin
                        rc = $fscanf(fd, "%h %h", f1, f2);
                        cfg_addr = cfg_addr_t'(f1);
                        #2;
                        if (cfg_rdata !== f2) begin
                            report_mismatch(name, f2, cfg_rdata);
                        end
                        next_cycle();
                    end
                    "PK": begin
                        rc = $fscanf(fd, "%h %h %h", f1, f2, f3);
                        if (tree_credits[f2[3:0]] == 0) begin
                            errors++;
                            $display("%0s: tree sent to port %0d without a credit", name, f2);
                        end
                        tree_credits[f2[3:0]]--;
                        din_leaf_bft2interface = {1'b1, leaf_id_t'(f1), port_id_t'(f2),
                                                  pkt_addr_t'(0), f3};
                        next_cycle();
                        din_leaf_bft2interface = '0;
                        if (leaf_id_t'(f1) == own_id && f2 >= 1 && f2 <= NUM_IN_PORTS) begin
                            rx_pending[f2 - 1]++;
                        end
                    end
                    "RX": begin
                        rc = $fscanf(fd, "%h %h", f1, f2);
                        p = int'(f1) - 1;
                        if (vld_interface2user[p] !== 1'b1) begin
                            errors++;
                            $display("%0s: no payload waiting on port %0d", name, f1);
                        end else begin
                            if (dout_leaf_interface2user[p] !== f2) begin
                                report_mismatch(name, f2, dout_leaf_interface2user[p]);
                            end
                            ack_user2interface[p] = 1'b1;
                            next_cycle();
                            ack_user2interface[p] = 1'b0;
                            rx_pending[p]--;
                            if (credit_out !== 1'b1 || credit_out_port !== port_id_t'(f1)) begin
                                report_mismatch(name, {1'b1, port_id_t'(f1)},
                                                {credit_out, credit_out_port});
                            end
                        end
                    end
                    "TX": begin
                        rc = $fscanf(fd, "%h %h", f1, f2);
                        for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                            if (f1[i]) begin
                                vld_user2interface[i]      = 1'b1;
                                din_leaf_user2interface[i] = f2 + 32'(i + 1);
                            end
                        end
                        next_cycle();
                    end
                    "EP": begin
                        rc = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                        exp_pkt = {1'b1, leaf_id_t'(f1), port_id_t'(f2), pkt_addr_t'(f3), f4};
                        while (sent_pkts.size() == 0) begin
                            next_cycle();
                        end
                        pkt = sent_pkts.pop_front();
                        if (pkt !== exp_pkt) begin
                            report_mismatch(name, exp_pkt, pkt);
                        end
                    end
                    "CI": begin
                        rc = $fscanf(fd, "%d %h", f1, f2);
                        repeat (2) next_cycle();
                        if (vld_user2interface !== f2[NUM_OUT_PORTS-1:0]) begin
                            report_mismatch(name, f2, vld_user2interface);
                        end
                        if (sent_pkts.size() != 0) begin
                            errors++;
                            $display("%0s: a packet left the leaf that no line expected", name);
                        end
                        repeat (f1) begin
                            credit_in = 1'b1;
                            next_cycle();
                            tx_credits++;
                        end
                        credit_in = 1'b0;
                    end
                    default: begin
                        errors++;
                        $display("Unknown opcode in the case file on line %0s", name);
                    end
                endcase
                if (vld_interface2user !== expected_rx_vld()) begin
                    report_mismatch(name, expected_rx_vld(), vld_interface2user);
                end
                gap = $random(seed) & 3;
                repeat (gap) next_cycle();
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int               fd;
        int               line_count;
        logic [8*128-1:0] text;
        rst_n                   = 1'b0;
        cfg_wr                  = 1'b0;
        cfg_addr                = '0;
        cfg_wdata               = '0;
        din_leaf_bft2interface  = '0;
        credit_in               = 1'b0;
        ack_user2interface      = '0;
        din_leaf_user2interface = '0;
        vld_user2interface      = '0;
        tx_credits              = TX_CREDITS;
        own_id                  = '0;
        line_count              = 0;
        for (int i = 0; i < 16; i++) begin
            tree_credits[i] = FIFO_DEPTH;
        end
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            rx_pending[i] = 0;
        end
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the case file %s", CASE_FILE);
        end else begin
            while ($fgets(text, fd) != 0) begin
                line_count++;
            end
            $fclose(fd);
            timeout_cycles = 200 * line_count + 100;
            repeat (8) next_cycle();
            rst_n = 1'b1;
            run_cases();
            repeat (5) next_cycle();
            // Every packet the tree sent must have come back as a credit
            for (int i = 0; i < 16; i++) begin
                if (tree_credits[i] != FIFO_DEPTH) begin
                    errors++;
                    $display("Port %0d ended with %0d tree credits", i, tree_credits[i]);
                end
            end
            if (sent_pkts.size() != 0 || vld_user2interface != '0) begin
                errors++;
                $display("User words or sent packets were left over at the end");
            end
        end
        $display("Run finished with %0d errors after %0d cycles", errors, cycle_count);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bft_leaf.f
src/bft_leaf_pkg.sv
src/port_fifo.sv
src/leaf_config_regs.sv
src/leaf_packet_rx.sv
src/leaf_packet_tx.sv
src/bft_leaf.sv
dv/clk_gen.sv
dv/tb_bft_leaf.sv

//--- run_sim.sh
#!/bin/sh
# Build the bft_leaf testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_bft_leaf -f bft_leaf.f -o sim_bft_leaf
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_bft_leaf > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- dv/bft_leaf_cases.txt
# op name then fields in hex: CW/CR addr data, PK leaf port payload, RX port payload
# TX port_mask base (port p sends base+p), EP leaf port addr payload, CI pulses pending_mask
CW cfg_id 0 0000000b
CW cfg_r1 1 00000035
CW cfg_r2 2 000001f2
CW cfg_r3 3 000000a7
CW cfg_r5 5 00000141
CW cfg_r7 7 00000063
CR rd_id 0 0000000b
CR rd_r2 2 000001f2
CR rd_r7 7 00000063
CR rd_unused 9 00000000
PK dlv_a 0b 2 aaaa0001
PK dlv_b 0b 2 aaaa0002
PK dlv_c 0b 7 bbbb0001
PK drop_leaf 0c 3 dead0001
PK drop_port0 0b 0 dead0002
PK drop_port9 0b 9 dead0003
RX dlv_a 2 aaaa0001
RX dlv_b 2 aaaa0002
RX dlv_c 7 bbbb0001
TX form_p1 01 11110000
EP form_p1 03 5 01 11110001
TX form_p3 04 22220000
EP form_p3 0a 7 03 22220003
CI form_ret 2 00
TX bp_rr 1f 33330000
EP bp_p4 00 0 04 33330004
EP bp_p5 14 1 05 33330005
EP bp_p1 03 5 01 33330001
EP bp_p2 1f 2 02 33330002
CI bp_stall 1 04
EP bp_p3 0a 7 03 33330003
CI bp_ret 4 00
TX rr_mix 62 44440000
EP rr_p6 00 0 06 44440006
EP rr_p7 06 3 07 44440007
EP rr_p2 1f 2 02 44440002
CI rr_ret 3 00
